//--- Makefile
TOP := uart_tb

.PHONY: all lint clean

all:
	verilator --binary --assert -j 0 --top-module $(TOP) -f flist.f
	./obj_dir/V$(TOP)

lint:
	verilator --lint-only --timing --assert --top-module $(TOP) -f flist.f

clean:
	rm -rf obj_dir

//--- dv/uart_tb.sv
`timescale 1ns/1ns
module uart_tb;
	import uart_pkg::*;

	localparam int DIVISOR = 1;
	localparam int CMD_MAX = 128;   // command slots, three words each

	localparam logic [7:0] OP_END      = 8'h00;
	localparam logic [7:0] OP_WRITE    = 8'h01;
	localparam logic [7:0] OP_READ     = 8'h02;
	localparam logic [7:0] OP_WAIT_LSR = 8'h03;
	localparam logic [7:0] OP_WAIT_INT = 8'h04;
	localparam logic [7:0] OP_FRAME    = 8'h05;
	localparam logic [7:0] OP_BURST    = 8'h06;
	localparam logic [7:0] OP_DRAIN    = 8'h07;

	logic       clk = 1'b0;
	logic       wb_rst_i;
	logic       wb_we_i;
	logic       wb_re_i;
	logic [2:0] wb_addr_i;
	logic [7:0] wb_dat_i;
	logic [7:0] wb_dat_o;
	logic       rx_i;
	logic       tx_o;
	logic       int_o;

	logic [7:0] cmd_mem [CMD_MAX*3];
	logic [7:0] exp_q [$];          // bytes sent in loopback, oldest first
	integer     seed;
	int         cycle_count;
	int         cycle_limit;

	uart_top #(
		.DL_RESET    (16'(DIVISOR)),
		.SYNC_STAGES (2)
	) uart_top_inst (
		.clk       (clk),
		.wb_rst_i  (wb_rst_i),
		.wb_we_i   (wb_we_i),
		.wb_re_i   (wb_re_i),
		.wb_addr_i (wb_addr_i),
		.wb_dat_i  (wb_dat_i),
		.wb_dat_o  (wb_dat_o),
		.rx_i      (rx_i),
		.tx_o      (tx_o),
		.int_o     (int_o)
	);

	always
	begin
		#2 clk = ~clk;
	end

	task automatic abort_run(input string why);
		$display("%s", why);
		$display("Simulation failed");
		$fatal(1);
	endtask

	task automatic check_value(input logic [7:0] got, input logic [7:0] expected,
			input string what);
		if (got !== expected)
			abort_run($sformatf("CHECK FAILED at %0t ns: %s, read %02h, expected %02h",
				$time, what, got, expected));
	endtask

	// runaway guard, limit set from the command list
	always @(posedge clk)
	begin
		if (wb_rst_i)
			cycle_count <= 0;
		else
		begin
			cycle_count <= cycle_count + 1;
			if (cycle_count >= cycle_limit)
				abort_run($sformatf("timeout: run took more than %0d cycles", cycle_limit));
		end
	end

	// every transmit here runs in loopback, so the pin rests at 1 throughout
	always @(negedge clk)
	begin
		if (wb_rst_i === 1'b0)
			check_value({7'b0, tx_o}, 8'h01, "tx_o not held idle");
	end

	task automatic bus_write(input logic [2:0] addr, input logic [7:0] data);
		@(posedge clk);
		wb_we_i   <= 1'b1;
		wb_addr_i <= addr;
		wb_dat_i  <= data;
		@(posedge clk);
		wb_we_i <= 1'b0;
	endtask

	// read data is combinational, taken mid cycle
	task automatic bus_read(input logic [2:0] addr, output logic [7:0] data);
		@(posedge clk);
		wb_re_i   <= 1'b1;
		wb_addr_i <= addr;
		@(negedge clk);
		data = wb_dat_o;
		@(posedge clk);
		wb_re_i <= 1'b0;
	endtask

	task automatic wait_lsr(input logic [7:0] mask);
		logic [7:0] lsr;
		lsr = '0;
		while ((lsr & mask) != mask)
			bus_read(REG_LS, lsr);
	endtask

	task automatic wait_int(input logic level);
		@(negedge clk);
		while (int_o !== level)
			@(negedge clk);
	endtask

	// start bit, 8 data bits lsb first, chosen stop bit
	task automatic send_frame(input logic [7:0] data, input logic stop_bit);
		logic [9:0] frame;
		int         i;
		frame = {stop_bit, data, 1'b0};
		for (i = 0; i < 10; i++)
		begin
			@(posedge clk);
			rx_i <= frame[i];
			repeat (16*DIVISOR-1) @(posedge clk);
		end
		@(posedge clk);
		rx_i <= 1'b1;
	endtask

	task automatic send_burst(input logic [7:0] count);
		integer     rnd;
		logic [7:0] b;
		repeat (count)
		begin
			rnd = $random(seed);
			b = rnd[7:0];
			exp_q.push_back(b);
			bus_write(REG_RB_TR, b);
		end
	endtask

	task automatic drain_rx(input logic [7:0] count);
		logic [7:0] rd;
		repeat (count)
		begin
			if (exp_q.size() == 0)
				abort_run("rx drain asked for more bytes than were sent");
			wait_lsr(8'h01 << LSR_DR);
			bus_read(REG_RB_TR, rd);
			check_value(rd, exp_q.pop_front(), "loopback byte");
		end
	endtask

	initial
	begin
		int         k;
		int         pc;
		int         frames;
		logic [7:0] op;
		logic [7:0] arg;
		logic [7:0] val;
		logic [7:0] rd;

		wb_rst_i  = 1'b1;
		wb_we_i   = 1'b0;
		wb_re_i   = 1'b0;
		wb_addr_i = '0;
		wb_dat_i  = '0;
		rx_i      = 1'b1;   // line idle
		seed      = 32'h7763;
		for (k = 0; k < CMD_MAX*3; k++)
			cmd_mem[k] = OP_END;
		$readmemh("dv/uart_tests.txt", cmd_mem);

		// one frame per command, plus one per burst byte
		frames = 0;
		for (k = 0; k < CMD_MAX && cmd_mem[k*3] != OP_END; k++)
			frames = frames + 1 + ((cmd_mem[k*3] == OP_BURST) ? int'(cmd_mem[k*3+1]) : 0);
		cycle_limit = frames * 16 * DIVISOR * 12 + 2000;

		repeat (2) @(posedge clk);
		wb_rst_i <= 1'b0;

		pc = 0;
		while (pc < CMD_MAX && cmd_mem[pc*3] != OP_END)
		begin
			op  = cmd_mem[pc*3];
			arg = cmd_mem[pc*3+1];
			val = cmd_mem[pc*3+2];
			case (op)
				OP_WRITE:    bus_write(arg[2:0], val);
				OP_READ:
				begin
					bus_read(arg[2:0], rd);
					check_value(rd, val, $sformatf("command %0d, register %0d", pc, arg));
				end
				OP_WAIT_LSR: wait_lsr(val);
				OP_WAIT_INT: wait_int(val[0]);
				OP_FRAME:    send_frame(val, arg[0]);
				OP_BURST:    send_burst(arg);
				OP_DRAIN:    drain_rx(arg);
				default:
					abort_run($sformatf("unknown opcode %02h in command %0d", op, pc));
			endcase
			pc++;
		end

		if (exp_q.size() != 0)
			abort_run($sformatf("%0d loopback bytes were never read back", exp_q.size()));
		else
		begin
			$display("Simulation passed");
			$finish;
		end
	end

endmodule

//--- dv/uart_tests.txt
// columns: opcode  arg  value, all hex
// 1 write, 2 read+compare, 3 wait lsr mask, 4 wait int level, 5 frame (arg stop bit), 6 burst, 7 drain, 0 end
// reset values
2 3 03
2 1 00
2 2 C1
2 5 60
4 0 0
// divisor latch, ier and scratch
1 3 83
1 0 34
1 1 12
2 0 34
2 1 12
2 3 83
1 0 01
1 1 00
2 0 01
1 3 03
1 1 05
2 1 05
1 1 00
1 7 A5
2 7 A5
// loopback burst of 8
1 4 10
6 8 0
7 7 0
3 0 41
2 5 61
7 1 0
2 5 60
// external frame with a bad stop bit
1 4 00
1 1 04
5 0 A7
4 0 1
2 2 C6
2 5 E9
2 5 61
4 0 0
2 0 A7
2 5 60
1 1 00
// trigger level 4, then overrun
1 4 10
1 2 46
1 1 01
6 4 0
4 0 1
2 2 C4
7 1 0
4 0 0
2 2 C1
7 3 0
6 8 0
3 0 40
6 8 0
3 0 40
1 1 04
4 0 0
1 0 3C
4 0 1
2 2 C6
2 5 E3
7 10 0
2 5 60
// thre interrupt
1 1 02
4 0 1
2 2 C2
4 0 0
2 2 C1
1 0 5A
4 0 1
2 2 C2
3 0 01
2 0 5A
2 5 60
1 1 00
0 0 0

//--- flist.f
logic/uart_pkg.sv
logic/uart_host_regs.sv
logic/uart_baud_gen.sv
logic/uart_tx.sv
logic/uart_rx.sv
logic/uart_status_irq.sv
logic/uart_top.sv
dv/uart_tb.sv

//--- logic/uart_baud_gen.sv
`timescale 1ns/1ns
module uart_baud_gen (
	input  logic                 clk,
	input  logic                 wb_rst_i,
	input  uart_pkg::uart_ctrl_t ctrl_i,
	output logic                 enable_o
);

	logic [15:0] dlc;   // down-counter

	always_ff @(posedge clk or posedge wb_rst_i)
	begin
		if (wb_rst_i)
		begin
			dlc      <= '0;
			enable_o <= 1'b0;
		end
		else
		begin
			if (ctrl_i.dl_restart || dlc == '0)
				dlc <= ctrl_i.divisor - 16'd1;
			else
				dlc <= dlc - 16'd1;
			// no ticks at all with a zero divisor
			enable_o <= dlc == '0 && ctrl_i.divisor != '0;
		end
	end

endmodule

//--- logic/uart_host_regs.sv
`timescale 1ns/1ns
module uart_host_regs #(
	parameter logic [15:0] DL_RESET = 16'd1
) (
	input  logic                 clk,
	input  logic                 wb_rst_i,
	input  uart_pkg::host_req_t  req_i,
	input  uart_pkg::rx_stat_t   rx_stat_i,
	input  logic [7:0]           lsr_i,
	input  logic [3:0]           iir_i,
	output uart_pkg::uart_ctrl_t ctrl_o,
	output logic                 loopback_o,
	output logic [7:0]           rd_data_o
);
	import uart_pkg::*;

	logic [7:0]  lcr;
	logic [2:0]  ier;        // {rls, thre, rda}
	logic [15:0] dl;
	logic [1:0]  trig_sel;
	logic [4:0]  mcr;
	logic [7:0]  scratch;
	logic        dlab;
	wr_data_u    wr_u;

	logic        wr_thr;
	logic        wr_dl;
	logic        wr_fcr;
	logic        rd_rb;
	logic        rd_iir;
	logic        lsr_cond;

	logic        thr_wr_q;
	logic        rb_rd_q;
	logic        restart_q;
	logic        rx_rst_q;
	logic        tx_rst_q;
	logic        lsr_cond_d;
	logic        lsr_rd_q;
	logic        iir_rd_q;
	logic [7:0]  tx_data_q;

	assign dlab       = lcr[LCR_DLAB];
	assign loopback_o = mcr[MCR_LOOP];
	assign wr_u       = req_i.dat;

	assign wr_thr   = req_i.we && req_i.addr == REG_RB_TR && !dlab;
	assign wr_dl    = req_i.we && dlab && (req_i.addr == REG_RB_TR || req_i.addr == REG_IE);
	assign wr_fcr   = req_i.we && req_i.addr == REG_II_FC;
	assign rd_rb    = req_i.re && req_i.addr == REG_RB_TR && !dlab;
	assign rd_iir   = req_i.re && req_i.addr == REG_II_FC;
	assign lsr_cond = req_i.re && req_i.addr == REG_LS;

	always_ff @(posedge clk or posedge wb_rst_i)
	begin
		if (wb_rst_i)
		begin
			lcr      <= 8'h03;   // 8n1
			ier      <= '0;
			dl       <= DL_RESET;
			trig_sel <= 2'b11;
			mcr      <= '0;
			scratch  <= '0;
		end
		else if (req_i.we)
		begin
			case (req_i.addr)
				REG_RB_TR:
					if (dlab)
						dl[7:0] <= wr_u.raw;
				REG_IE:
					if (dlab)
						dl[15:8] <= wr_u.raw;
					else
						ier <= {wr_u.ier.rls_en, wr_u.ier.thre_en, wr_u.ier.rda_en};
				REG_II_FC: trig_sel <= wr_u.fcr.trig;
				REG_LC:    lcr      <= wr_u.raw;
				REG_MC:    mcr      <= wr_u.raw[4:0];
				REG_SR:    scratch  <= wr_u.raw;
				default: ;
			endcase
		end
	end

	// command pulses, one cycle after the strobe
	always_ff @(posedge clk or posedge wb_rst_i)
	begin
		if (wb_rst_i)
		begin
			thr_wr_q   <= 1'b0;
			rb_rd_q    <= 1'b0;
			restart_q  <= 1'b0;
			rx_rst_q   <= 1'b0;
			tx_rst_q   <= 1'b0;
			lsr_cond_d <= 1'b0;
			lsr_rd_q   <= 1'b0;
			iir_rd_q   <= 1'b0;
		end
		else
		begin
			thr_wr_q   <= wr_thr;
			rb_rd_q    <= rd_rb;
			restart_q  <= wr_dl;
			rx_rst_q   <= wr_fcr && wr_u.fcr.rx_reset;
			tx_rst_q   <= wr_fcr && wr_u.fcr.tx_reset;
			lsr_cond_d <= lsr_cond;
			lsr_rd_q   <= lsr_cond && !lsr_cond_d;   // held read clears once
			iir_rd_q   <= rd_iir;
		end
	end

	always_ff @(posedge clk)
	begin
		if (wr_thr)
			tx_data_q <= req_i.dat;
	end

	// combinational read, head byte shown is the one popped
	always_comb
	begin
		case (req_i.addr)
			REG_RB_TR: rd_data_o = dlab ? dl[7:0] : rx_stat_i.data;
			REG_IE:    rd_data_o = dlab ? dl[15:8] : {5'b0, ier};
			REG_II_FC: rd_data_o = {4'hC, iir_i};
			REG_LC:    rd_data_o = lcr;
			REG_MC:    rd_data_o = {3'b0, mcr};
			REG_LS:    rd_data_o = lsr_i;
			REG_SR:    rd_data_o = scratch;
			default:   rd_data_o = 8'h00;
		endcase
	end

	always_comb
	begin
		ctrl_o.divisor    = dl;
		ctrl_o.dl_restart = restart_q;
		ctrl_o.tx_push    = thr_wr_q;
		ctrl_o.tx_data    = tx_data_q;
		ctrl_o.rx_pop     = rb_rd_q;
		ctrl_o.rx_reset   = rx_rst_q;
		ctrl_o.tx_reset   = tx_rst_q;
		ctrl_o.rls_en     = ier[2];
		ctrl_o.thre_en    = ier[1];
		ctrl_o.rda_en     = ier[0];
		ctrl_o.trig_sel   = trig_sel;
		ctrl_o.lsr_read   = lsr_rd_q;
		ctrl_o.iir_read   = iir_rd_q;
		ctrl_o.rb_read    = rb_rd_q;
		ctrl_o.thr_write  = thr_wr_q;
	end

	a_push_vs_restart: assert property (@(posedge clk) disable iff (wb_rst_i)
		!(ctrl_o.tx_push && ctrl_o.dl_restart))
		else $error("tx push and divisor restart together");

endmodule

//--- logic/uart_pkg.sv
package uart_pkg;

	// register map on the 3-bit host address
	localparam logic [2:0] REG_RB_TR = 3'd0;
	localparam logic [2:0] REG_IE    = 3'd1;
	localparam logic [2:0] REG_II_FC = 3'd2;
	localparam logic [2:0] REG_LC    = 3'd3;
	localparam logic [2:0] REG_MC    = 3'd4;
	localparam logic [2:0] REG_LS    = 3'd5;
	localparam logic [2:0] REG_SR    = 3'd7;

	localparam int LCR_DLAB = 7;
	localparam int MCR_LOOP = 4;

	// line status bit positions
	localparam int LSR_DR   = 0;
	localparam int LSR_OE   = 1;
	localparam int LSR_FE   = 3;
	localparam int LSR_THRE = 5;
	localparam int LSR_TEMT = 6;
	localparam int LSR_ERR  = 7;

	localparam int FIFO_DEPTH = 16;
	localparam int FIFO_CNT_W = 5;

	// interrupt id, sits in iir[3:1]
	localparam logic [2:0] IIR_RLS  = 3'd3;
	localparam logic [2:0] IIR_RDA  = 3'd2;
	localparam logic [2:0] IIR_THRE = 3'd1;
	localparam logic [2:0] IIR_NONE = 3'd0;

	typedef struct packed {
		logic       we;
		logic       re;
		logic [2:0] addr;
		logic [7:0] dat;
	} host_req_t;

	typedef struct packed {
		logic [1:0] trig;
		logic [2:0] rsvd_hi;
		logic       tx_reset;
		logic       rx_reset;
		logic       rsvd_lo;   // fifo enable, always on here
	} fcr_t;

	typedef struct packed {
		logic [4:0] rsvd;      // bit 3 was modem status
		logic       rls_en;
		logic       thre_en;
		logic       rda_en;
	} ier_t;

	// one host byte, seen as fcr, ier or plain divisor data
	typedef union packed {
		fcr_t       fcr;
		ier_t       ier;
		logic [7:0] raw;
	} wr_data_u;

	typedef struct packed {
		logic [15:0] divisor;
		logic        dl_restart;
		logic        tx_push;
		logic [7:0]  tx_data;
		logic        rx_pop;
		logic        rx_reset;
		logic        tx_reset;
		logic        rls_en;
		logic        thre_en;
		logic        rda_en;
		logic [1:0]  trig_sel;
		logic        lsr_read;
		logic        iir_read;
		logic        rb_read;
		logic        thr_write;
	} uart_ctrl_t;

	typedef struct packed {
		logic [7:0]            data;   // fifo head
		logic                  fe;     // framing error of the head entry
		logic [FIFO_CNT_W-1:0] count;
		logic                  push;
		logic                  overrun;
	} rx_stat_t;

	typedef struct packed {
		logic [FIFO_CNT_W-1:0] count;
		logic                  idle;
	} tx_stat_t;

endpackage

//--- logic/uart_rx.sv
`timescale 1ns/1ns
module uart_rx #(
	parameter int SYNC_STAGES = 2
) (
	input  logic                 clk,
	input  logic                 wb_rst_i,
	input  uart_pkg::uart_ctrl_t ctrl_i,
	input  logic                 enable_i,
	input  logic                 serial_i,
	output uart_pkg::rx_stat_t   rx_stat_o
);
	import uart_pkg::*;

	localparam int PTR_W = $clog2(FIFO_DEPTH);
	localparam logic [FIFO_CNT_W-1:0] FULL = FIFO_CNT_W'(FIFO_DEPTH);

	typedef enum logic [2:0] {IDLE, START, DATA, STOP, DONE} rx_state_e;

	logic [SYNC_STAGES-1:0] sync_q;
	logic                   rx_in;
	logic                   rx_prev;   // line at the previous enable
	rx_state_e              state;
	logic [3:0]             tick;
	logic [2:0]             bit_idx;
	logic [7:0]             shift;
	logic                   fe_q;
	logic                   frame_done;
	logic [8:0]             mem [FIFO_DEPTH];   // {fe, data}
	logic [PTR_W-1:0]       wr_ptr;
	logic [PTR_W-1:0]       rd_ptr;
	logic [FIFO_CNT_W-1:0]  count;
	logic                   push_ok;
	logic                   pop;

	assign rx_in = sync_q[SYNC_STAGES-1];

	always_ff @(posedge clk or posedge wb_rst_i)
	begin
		if (wb_rst_i)
			sync_q <= '1;   // line idles high
		else
			sync_q <= (sync_q << 1) | SYNC_STAGES'(serial_i);
	end

	always_ff @(posedge clk or posedge wb_rst_i)
	begin
		if (wb_rst_i)
		begin
			state   <= IDLE;
			tick    <= '0;
			bit_idx <= '0;
			rx_prev <= 1'b1;
		end
		else if (enable_i)
		begin
			rx_prev <= rx_in;
			tick    <= tick + 4'd1;
			case (state)
				IDLE:
				begin
					tick <= '0;
					if (rx_prev && !rx_in)   // falling edge
						state <= START;
				end
				START:
					if (tick == 4'd7)
					begin
						tick  <= '0;
						state <= rx_in ? IDLE : DATA;   // mid start bit, else a glitch
					end
				DATA:
					if (tick == 4'd15)
					begin
						bit_idx <= bit_idx + 3'd1;
						if (bit_idx == 3'd7)
							state <= STOP;
					end
				STOP:
					if (tick == 4'd15)
						state <= DONE;
				default:
					if (tick == 4'd7)   // half a bit after the stop sample
						state <= IDLE;
			endcase
		end
	end

	always_ff @(posedge clk)
	begin
		if (enable_i && tick == 4'd15)
		begin
			if (state == DATA)
				shift <= {rx_in, shift[7:1]};
			else if (state == STOP)
				fe_q <= !rx_in;
		end
	end

	assign frame_done = enable_i && state == DONE && tick == 4'd7;
	assign push_ok    = frame_done && count != FULL;
	assign pop        = ctrl_i.rx_pop && count != '0;

	always_ff @(posedge clk)
	begin
		if (push_ok)
			mem[wr_ptr] <= {fe_q, shift};
	end

	always_ff @(posedge clk or posedge wb_rst_i)
	begin
		if (wb_rst_i || ctrl_i.rx_reset)
		begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count  <= '0;
		end
		else
		begin
			if (push_ok)
				wr_ptr <= wr_ptr + 1'b1;
			if (pop)
				rd_ptr <= rd_ptr + 1'b1;
			count <= count + FIFO_CNT_W'(push_ok) - FIFO_CNT_W'(pop);
		end
	end

	assign rx_stat_o.data    = mem[rd_ptr][7:0];
	assign rx_stat_o.fe      = mem[rd_ptr][8];
	assign rx_stat_o.count   = count;
	assign rx_stat_o.push    = frame_done;
	assign rx_stat_o.overrun = frame_done && count == FULL;   // byte dropped

	a_overrun_full: assert property (@(posedge clk) disable iff (wb_rst_i)
		rx_stat_o.overrun |-> count == FULL && wr_ptr == rd_ptr)
		else $error("rx overrun without a full fifo");

endmodule

//--- logic/uart_status_irq.sv
`timescale 1ns/1ns
module uart_status_irq (
	input  logic                 clk,
	input  logic                 wb_rst_i,
	input  uart_pkg::uart_ctrl_t ctrl_i,
	input  uart_pkg::rx_stat_t   rx_stat_i,
	input  uart_pkg::tx_stat_t   tx_stat_i,
	output logic [7:0]           lsr_o,
	output logic [3:0]           iir_o,
	output logic                 int_o
);
	import uart_pkg::*;

	logic                  oe;
	logic                  fe;
	logic                  err;
	logic                  thre;
	logic                  temt;
	logic                  fe_head;
	logic                  fe_head_d;
	logic                  err_cond;
	logic                  err_d;
	logic                  tx_empty;
	logic [FIFO_CNT_W-1:0] trig_lvl;
	logic                  rls_pnd;
	logic                  rda_pnd;
	logic                  thre_pnd;
	logic                  thre_cond;
	logic                  thre_cond_d;
	logic                  iir_thre_d;   // iir showed thre during the read

	assign fe_head   = rx_stat_i.fe && rx_stat_i.count != '0;
	assign err_cond  = fe_head || rx_stat_i.overrun;
	assign tx_empty  = tx_stat_i.count == '0;
	assign thre_cond = ctrl_i.thre_en && thre;

	always_comb
	begin
		case (ctrl_i.trig_sel)
			2'd0:    trig_lvl = 5'd1;
			2'd1:    trig_lvl = 5'd4;
			2'd2:    trig_lvl = 5'd8;
			default: trig_lvl = 5'd14;
		endcase
	end

	always_ff @(posedge clk or posedge wb_rst_i)
	begin
		if (wb_rst_i)
		begin
			oe          <= 1'b0;
			fe          <= 1'b0;
			err         <= 1'b0;
			fe_head_d   <= 1'b0;
			err_d       <= 1'b0;
			thre        <= 1'b1;
			temt        <= 1'b1;
			rls_pnd     <= 1'b0;
			rda_pnd     <= 1'b0;
			thre_pnd    <= 1'b0;
			thre_cond_d <= 1'b0;
			iir_thre_d  <= 1'b0;
			int_o       <= 1'b0;
		end
		else
		begin
			fe_head_d <= fe_head;
			err_d     <= err_cond;
			oe   <= ctrl_i.lsr_read ? 1'b0 : oe || rx_stat_i.overrun;
			fe   <= ctrl_i.lsr_read ? 1'b0 : fe || (fe_head && !fe_head_d);   // set on rise
			err  <= ctrl_i.lsr_read ? 1'b0 : err || (err_cond && !err_d);
			thre <= ctrl_i.thr_write ? 1'b0 : tx_empty;
			temt <= ctrl_i.thr_write ? 1'b0 : tx_empty && tx_stat_i.idle;

			rls_pnd <= ctrl_i.rls_en && (oe || fe);
			// a pop at the trigger level drops rda one cycle early
			rda_pnd <= ctrl_i.rda_en && rx_stat_i.count >= trig_lvl
				&& !(ctrl_i.rb_read && rx_stat_i.count == trig_lvl && !rx_stat_i.push);
			thre_cond_d <= thre_cond;
			iir_thre_d  <= iir_o == {IIR_THRE, 1'b0};
			if (ctrl_i.thr_write || (ctrl_i.iir_read && iir_thre_d))
				thre_pnd <= 1'b0;
			else if (thre_cond && !thre_cond_d)
				thre_pnd <= 1'b1;
			else
				thre_pnd <= thre_pnd && ctrl_i.thre_en;

			int_o <= rls_pnd || rda_pnd || thre_pnd;
		end
	end

	always_comb
	begin
		lsr_o           = '0;
		lsr_o[LSR_DR]   = rx_stat_i.count != '0;
		lsr_o[LSR_OE]   = oe;
		lsr_o[LSR_FE]   = fe;
		lsr_o[LSR_THRE] = thre;
		lsr_o[LSR_TEMT] = temt;
		lsr_o[LSR_ERR]  = err;
	end

	// priority rls, rda, thre
	always_comb
	begin
		if (rls_pnd)
			iir_o = {IIR_RLS, 1'b0};
		else if (rda_pnd)
			iir_o = {IIR_RDA, 1'b0};
		else if (thre_pnd)
			iir_o = {IIR_THRE, 1'b0};
		else
			iir_o = {IIR_NONE, 1'b1};
	end

endmodule

//--- logic/uart_top.sv
`timescale 1ns/1ns
module uart_top #(
	parameter logic [15:0] DL_RESET    = 16'd1,
	parameter int          SYNC_STAGES = 2
) (
	input  logic       clk,
	input  logic       wb_rst_i,
	input  logic       wb_we_i,
	input  logic       wb_re_i,
	input  logic [2:0] wb_addr_i,
	input  logic [7:0] wb_dat_i,
	output logic [7:0] wb_dat_o,
	input  logic       rx_i,
	output logic       tx_o,
	output logic       int_o
);
	import uart_pkg::*;

	host_req_t  req;
	uart_ctrl_t ctrl;
	rx_stat_t   rx_stat;
	tx_stat_t   tx_stat;
	logic [7:0] lsr;
	logic [3:0] iir;
	logic       loopback;
	logic       enable;      // 16x bit rate
	logic       tx_serial;
	logic       rx_serial;

	assign req = '{we: wb_we_i, re: wb_re_i, addr: wb_addr_i, dat: wb_dat_i};

	// loopback keeps the pin idle and ignores rx_i
	assign rx_serial = loopback ? tx_serial : rx_i;
	assign tx_o      = loopback ? 1'b1 : tx_serial;

	uart_host_regs #(.DL_RESET(DL_RESET)) uart_host_regs_inst (
		.clk        (clk),
		.wb_rst_i   (wb_rst_i),
		.req_i      (req),
		.rx_stat_i  (rx_stat),
		.lsr_i      (lsr),
		.iir_i      (iir),
		.ctrl_o     (ctrl),
		.loopback_o (loopback),
		.rd_data_o  (wb_dat_o)
	);

	uart_baud_gen uart_baud_gen_inst (
		.clk      (clk),
		.wb_rst_i (wb_rst_i),
		.ctrl_i   (ctrl),
		.enable_o (enable)
	);

	uart_tx uart_tx_inst (
		.clk       (clk),
		.wb_rst_i  (wb_rst_i),
		.ctrl_i    (ctrl),
		.enable_i  (enable),
		.tx_stat_o (tx_stat),
		.serial_o  (tx_serial)
	);

	uart_rx #(.SYNC_STAGES(SYNC_STAGES)) uart_rx_inst (
		.clk       (clk),
		.wb_rst_i  (wb_rst_i),
		.ctrl_i    (ctrl),
		.enable_i  (enable),
		.serial_i  (rx_serial),
		.rx_stat_o (rx_stat)
	);

	uart_status_irq uart_status_irq_inst (
		.clk       (clk),
		.wb_rst_i  (wb_rst_i),
		.ctrl_i    (ctrl),
		.rx_stat_i (rx_stat),
		.tx_stat_i (tx_stat),
		.lsr_o     (lsr),
		.iir_o     (iir),
		.int_o     (int_o)
	);

endmodule

//--- logic/uart_tx.sv
`timescale 1ns/1ns
module uart_tx (
	input  logic                 clk,
	input  logic                 wb_rst_i,
	input  uart_pkg::uart_ctrl_t ctrl_i,
	input  logic                 enable_i,
	output uart_pkg::tx_stat_t   tx_stat_o,
	output logic                 serial_o
);
	import uart_pkg::*;

	localparam int PTR_W = $clog2(FIFO_DEPTH);
	localparam logic [FIFO_CNT_W-1:0] FULL = FIFO_CNT_W'(FIFO_DEPTH);

	typedef enum logic [1:0] {IDLE, START, DATA, STOP} tx_state_e;

	logic [7:0]            mem [FIFO_DEPTH];
	logic [PTR_W-1:0]      wr_ptr;
	logic [PTR_W-1:0]      rd_ptr;
	logic [FIFO_CNT_W-1:0] count;
	logic                  push_ok;
	logic                  pop;
	tx_state_e             state;
	logic [3:0]            tick;     // 16 enables per bit
	logic [2:0]            bit_idx;
	logic [7:0]            shift;

	assign push_ok = ctrl_i.tx_push && count != FULL;   // lost when full
	assign pop     = enable_i && state == IDLE && count != '0;

	always_ff @(posedge clk)
	begin
		if (push_ok)
			mem[wr_ptr] <= ctrl_i.tx_data;
	end

	always_ff @(posedge clk or posedge wb_rst_i)
	begin
		if (wb_rst_i || ctrl_i.tx_reset)
		begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count  <= '0;
		end
		else
		begin
			if (push_ok)
				wr_ptr <= wr_ptr + 1'b1;
			if (pop)
				rd_ptr <= rd_ptr + 1'b1;
			count <= count + FIFO_CNT_W'(push_ok) - FIFO_CNT_W'(pop);
		end
	end

	always_ff @(posedge clk or posedge wb_rst_i)
	begin
		if (wb_rst_i)
		begin
			state   <= IDLE;
			tick    <= '0;
			bit_idx <= '0;
		end
		else if (enable_i)
		begin
			tick <= (state == IDLE) ? 4'd0 : tick + 4'd1;
			case (state)
				IDLE:
					if (count != '0)
						state <= START;
				START:
					if (tick == 4'd15)
						state <= DATA;
				DATA:
					if (tick == 4'd15)
					begin
						bit_idx <= bit_idx + 3'd1;
						if (bit_idx == 3'd7)
							state <= STOP;
					end
				default:
					if (tick == 4'd15)
						state <= IDLE;
			endcase
		end
	end

	// lsb first
	always_ff @(posedge clk)
	begin
		if (pop)
			shift <= mem[rd_ptr];
		else if (enable_i && state == DATA && tick == 4'd15)
			shift <= shift >> 1;
	end

	always_comb
	begin
		case (state)
			START:   serial_o = 1'b0;
			DATA:    serial_o = shift[0];
			default: serial_o = 1'b1;   // idle and stop
		endcase
	end

	assign tx_stat_o.count = count;
	assign tx_stat_o.idle  = state == IDLE;

	a_tx_count: assert property (@(posedge clk) disable iff (wb_rst_i) count <= FULL)
		else $error("tx fifo count above depth");

endmodule
